//--- sa_pkg.sv
package sa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int pixel_w  = 8;
    localparam int weight_w = 8;

    // distance between the two packed pixel fields, used by packer and drain
    localparam int field_shift = 24;

    localparam int op_w     = field_shift + pixel_w + 1;    // 33 bits
    localparam int acc_w    = 56;
    localparam int result_w = field_shift;

    ////////////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic        [pixel_w-1:0]   pixel_t;          // uint8 pixel
    typedef logic        [2*pixel_w-1:0] pixel_pair_t;     // {high, low}
    typedef logic signed [weight_w-1:0]  weight_t;         // int8 weight
    typedef logic        [op_w-1:0]      packed_op_t;      // {hi << 24} + lo
    typedef logic signed [acc_w-1:0]     acc_t;
    typedef logic signed [result_w-1:0]  result_t;

    typedef enum logic {
        mode_pair   = 1'b0,     // two products per PE
        mode_single = 1'b1      // low pixel only
    } sa_mode_e;

    // width of a select over n entries, at least one bit
    function automatic int sel_width(int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

//--- sa_operand_if.sv
`timescale 1ns/1ps

// operands leaving the packer, already skewed into systolic order
interface sa_operand_if import sa_pkg::*; #(
    parameter int rows = 4,
    parameter int cols = 4
) ();

    weight_t         w     [rows];  // left edge, one per row
    packed_op_t      op    [cols];  // top edge, one per column
    logic [rows-1:0] en;            // skewed by row index
    logic [rows-1:0] clear;         // same skew as en

    modport packer (
        output w,
        output op,
        output en,
        output clear
    );

    modport array (
        input w,
        input op,
        input en,
        input clear
    );

endinterface

//--- sa_operand_packer.sv
`timescale 1ns/1ps

module sa_operand_packer import sa_pkg::*; #(
    parameter int rows = 4,
    parameter int cols = 4
) (
    input  logic          clk,
    input  logic          channel_out_reset,
    input  sa_mode_e      mode_init,
    input  logic          en,
    input  logic          clear,
    input  weight_t       row_in    [rows],
    input  pixel_pair_t   column_in [cols],
    sa_operand_if.packer  ops,
    output sa_mode_e      mode
);

    ////////////////////////////////////////////////////////////////////////////
    // mode register, loaded while reset is held
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            mode <= mode_init;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // row side: weight, enable and clear, delayed by the row index
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < rows; i++) begin : g_row
        weight_t    w_sr [i+1];     // stage 0 is the input register
        logic [i:0] en_sr;
        logic [i:0] clr_sr;

        always_ff @(posedge clk) begin
            w_sr[0] <= row_in[i];
            for (int d = 1; d <= i; d++) begin
                w_sr[d] <= w_sr[d-1];
            end
        end

        always_ff @(posedge clk) begin
            if (channel_out_reset) begin
                en_sr  <= '0;
                clr_sr <= '0;
            end else begin
                en_sr[0]  <= en;
                clr_sr[0] <= clear;
                for (int d = 1; d <= i; d++) begin
                    en_sr[d]  <= en_sr[d-1];
                    clr_sr[d] <= clr_sr[d-1];
                end
            end
        end

        assign ops.w[i]     = w_sr[i];
        assign ops.en[i]    = en_sr[i];
        assign ops.clear[i] = clr_sr[i];
    end

    ////////////////////////////////////////////////////////////////////////////
    // column side: pack the pixel pair, then delay by the column index
    ////////////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < cols; j++) begin : g_col
        pixel_t     pix_hi;
        pixel_t     pix_lo;
        packed_op_t op_packed;
        packed_op_t op_sr [j+1];

        assign pix_hi = column_in[j][pixel_w +: pixel_w];
        assign pix_lo = column_in[j][0 +: pixel_w];

        // high pixel lands at field_shift, low pixel at bit 0
        always_comb begin
            if (mode == mode_pair) begin
                op_packed = (packed_op_t'(pix_hi) << field_shift) + packed_op_t'(pix_lo);
            end else begin
                op_packed = packed_op_t'(pix_lo);
            end
        end

        always_ff @(posedge clk) begin
            op_sr[0] <= op_packed;
            for (int d = 1; d <= j; d++) begin
                op_sr[d] <= op_sr[d-1];
            end
        end

        assign ops.op[j] = op_sr[j];
    end

endmodule

//--- sa_pe.sv
`timescale 1ns/1ps

module sa_pe import sa_pkg::*; (
    input  logic       clk,
    input  logic       channel_out_reset,
    input  logic       en,
    input  logic       clear,
    input  weight_t    w_in,
    input  packed_op_t op_in,
    output weight_t    w_out,
    output packed_op_t op_out,
    output acc_t       acc
);

    localparam int prod_w = weight_w + op_w + 1;

    logic signed [prod_w-1:0] prod;

    // packed operand is unsigned, so widen with a zero before the signed multiply
    assign prod = w_in * $signed({1'b0, op_in});

    ////////////////////////////////////////////////////////////////////////////
    // systolic pass-through, weight right and operand down
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        w_out  <= w_in;
        op_out <= op_in;
    end

    ////////////////////////////////////////////////////////////////////////////
    // accumulate
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            acc <= '0;
        end else if (en) begin
            if (clear) begin
                acc <= acc_t'(prod);        // first pair of a tile
            end else begin
                acc <= acc + acc_t'(prod);
            end
        end
    end

    // the skew chains in packer and array must keep clear inside the en window
    a_clear_with_en : assert property (
        @(posedge clk) disable iff (channel_out_reset)
        clear |-> en
    ) else $error("sa_pe: clear without en");

endmodule

//--- sa_array.sv
`timescale 1ns/1ps

module sa_array import sa_pkg::*; #(
    parameter int rows = 4,
    parameter int cols = 4
) (
    input  logic                       clk,
    input  logic                       channel_out_reset,
    sa_operand_if.array                ops,
    input  logic [sel_width(rows)-1:0] row_sel,
    output acc_t                       row_acc [cols]
);

    weight_t    w_h   [rows][cols+1];   // weight entering PE (i,j)
    packed_op_t op_v  [rows+1][cols];   // operand entering PE (i,j)
    logic       en_d  [rows][cols];     // en seen by PE (i,j)
    logic       clr_d [rows][cols];
    acc_t       acc_g [rows][cols];

    ////////////////////////////////////////////////////////////////////////////
    // PE grid
    ////////////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < cols; j++) begin : g_top
        assign op_v[0][j] = ops.op[j];
    end

    for (genvar i = 0; i < rows; i++) begin : g_row
        assign w_h[i][0]   = ops.w[i];
        assign en_d[i][0]  = ops.en[i];
        assign clr_d[i][0] = ops.clear[i];

        // one more cycle per column, matching the weight hop
        for (genvar j = 1; j < cols; j++) begin : g_skew
            always_ff @(posedge clk) begin
                if (channel_out_reset) begin
                    en_d[i][j]  <= 1'b0;
                    clr_d[i][j] <= 1'b0;
                end else begin
                    en_d[i][j]  <= en_d[i][j-1];
                    clr_d[i][j] <= clr_d[i][j-1];
                end
            end
        end

        for (genvar j = 0; j < cols; j++) begin : g_col
            sa_pe i_pe (
                .clk               (clk),
                .channel_out_reset (channel_out_reset),
                .en                (en_d[i][j]),
                .clear             (clr_d[i][j]),
                .w_in              (w_h[i][j]),
                .op_in             (op_v[i][j]),
                .w_out             (w_h[i][j+1]),
                .op_out            (op_v[i+1][j]),
                .acc               (acc_g[i][j])
            );
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // row read port
    ////////////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < cols; j++) begin : g_read
        assign row_acc[j] = acc_g[row_sel][j];  // combinational, same cycle
    end

    a_row_sel_range : assert property (
        @(posedge clk) disable iff (channel_out_reset)
        row_sel < rows
    ) else $error("sa_array: row_sel out of range");

endmodule

//--- sa_row_drain.sv
`timescale 1ns/1ps

module sa_row_drain import sa_pkg::*; #(
    parameter int rows = 4,
    parameter int cols = 4
) (
    input  logic                       clk,
    input  logic                       channel_out_reset,
    input  sa_mode_e                   mode,
    input  logic                       channel_out_en,
    output logic [sel_width(rows)-1:0] row_sel,
    input  acc_t                       row_acc [cols],
    output result_t                    out     [2*cols]
);

    localparam int row_w = sel_width(rows);

    logic    row_last;
    logic    hi_nonzero;
    result_t lo_res [cols];
    result_t hi_res [cols];

    ////////////////////////////////////////////////////////////////////////////
    // wrapping row counter
    ////////////////////////////////////////////////////////////////////////////

    assign row_last = (row_sel == row_w'(rows - 1));

    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            row_sel <= '0;
        end else if (channel_out_en) begin
            if (row_last) begin
                row_sel <= '0;
            end else begin
                row_sel <= row_sel + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // field split
    ////////////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < cols; j++) begin : g_split
        // low field taken as signed
        assign lo_res[j] = row_acc[j][field_shift-1:0];

        // a negative low field borrowed one from the high field
        assign hi_res[j] = row_acc[j][2*field_shift-1:field_shift]
                         + {{(field_shift-1){1'b0}}, lo_res[j][field_shift-1]};

        always_comb begin
            out[j]      = '0;
            out[cols+j] = '0;
            if (channel_out_en) begin
                out[j] = lo_res[j];
                if (mode == mode_pair) begin
                    out[cols+j] = hi_res[j];    // no high product in single mode
                end
            end
        end
    end

    always_comb begin
        hi_nonzero = 1'b0;
        for (int k = 0; k < cols; k++) begin
            hi_nonzero = hi_nonzero | (|hi_res[k]);
        end
    end

    // without a packed high pixel the high field holds only the low sign
    a_single_hi_zero : assert property (
        @(posedge clk) disable iff (channel_out_reset)
        (mode == mode_single) |-> !hi_nonzero
    ) else $error("sa_row_drain: high field set in single mode");

endmodule

//--- sa_top.sv
`timescale 1ns/1ps

module sa_top import sa_pkg::*; #(
    parameter int rows = 4,
    parameter int cols = 4
) (
    input  logic        clk,
    input  logic        channel_out_reset,
    input  sa_mode_e    mode_init,
    input  logic        en,
    input  logic        clear,
    input  weight_t     row_in    [rows],
    input  pixel_pair_t column_in [cols],
    input  logic        channel_out_en,
    output result_t     out       [2*cols]
);

    sa_mode_e                   mode;
    logic [sel_width(rows)-1:0] row_sel;
    acc_t                       row_acc [cols];

    sa_operand_if #(.rows(rows), .cols(cols)) ops ();

    ////////////////////////////////////////////////////////////////////////////
    // packer -> array -> drain
    ////////////////////////////////////////////////////////////////////////////

    sa_operand_packer #(.rows(rows), .cols(cols)) i_packer (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .mode_init         (mode_init),
        .en                (en),
        .clear             (clear),
        .row_in            (row_in),
        .column_in         (column_in),
        .ops               (ops.packer),
        .mode              (mode)
    );

    sa_array #(.rows(rows), .cols(cols)) i_array (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .ops               (ops.array),
        .row_sel           (row_sel),
        .row_acc           (row_acc)
    );

    // mode comes from the packer register
    sa_row_drain #(.rows(rows), .cols(cols)) i_drain (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .mode              (mode),
        .channel_out_en    (channel_out_en),
        .row_sel           (row_sel),
        .row_acc           (row_acc),
        .out               (out)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

// free running testbench clock
module tb_clock_gen #(
    parameter real period = 40.0     // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period / 2.0) clk = ~clk;

endmodule

//--- tb_sa_top.sv
`timescale 1ns/1ps

module tb_sa_top import sa_pkg::*; ();

    localparam int rows          = 4;
    localparam int cols          = 4;
    localparam int num_tiles     = 6;
    localparam int max_k         = 8;
    localparam int clk_period    = 40;
    localparam int reset_cycles  = 16;
    localparam int settle_cycles = rows + cols + 2;   // far PE sits rows+cols-2 behind

    logic        clk;
    logic        channel_out_reset;
    sa_mode_e    mode_init;
    logic        en;
    logic        clear;
    weight_t     row_in    [rows];
    pixel_pair_t column_in [cols];
    logic        channel_out_en;
    result_t     out       [2*cols];

    // stimulus and expected values, one entry per tile
    sa_mode_e tile_mode [num_tiles];
    int       tile_len  [num_tiles];
    weight_t  tile_w    [num_tiles][rows];
    pixel_t   tile_lo   [num_tiles][max_k][cols];
    pixel_t   tile_hi   [num_tiles][max_k][cols];
    result_t  exp_lo    [num_tiles][rows][cols];
    result_t  exp_hi    [num_tiles][rows][cols];

    int       seed = 32'h1368;
    int       exp_row;
    int       limit_cycles;
    logic     table_ready = 1'b0;
    sa_mode_e cur_mode;
    result_t  zero_row [2*cols];

    tb_clock_gen #(.period(clk_period)) i_clock_gen (.clk(clk));

    sa_top #(.rows(rows), .cols(cols)) i_sa_top (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .mode_init         (mode_init),
        .en                (en),
        .clear             (clear),
        .row_in            (row_in),
        .column_in         (column_in),
        .channel_out_en    (channel_out_en),
        .out               (out)
    );

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_table();
        tile_mode = '{mode_pair, mode_pair, mode_pair, mode_single, mode_single, mode_pair};
        tile_len  = '{8, 8, 3, 5, 1, 6};
        for (int t = 0; t < num_tiles; t++) begin
            for (int i = 0; i < rows; i++) begin
                tile_w[t][i] = weight_t'($random(seed));
            end
            for (int k = 0; k < max_k; k++) begin
                for (int j = 0; j < cols; j++) begin
                    tile_lo[t][k][j] = pixel_t'($random(seed));
                    tile_hi[t][k][j] = pixel_t'($random(seed));
                end
            end
        end
        // tile 1: negative weights on large pixels, low field goes negative
        tile_w[1] = '{weight_t'(-128), weight_t'(-1), weight_t'(-77), weight_t'(127)};
        for (int k = 0; k < max_k; k++) begin
            for (int j = 0; j < cols; j++) begin
                tile_lo[1][k][j] = 8'hff - pixel_t'(j);
                tile_hi[1][k][j] = (k % 2) ? 8'hff : 8'h00;
            end
        end
        // tile 4: single pass, extreme weights, high pixels must be ignored
        tile_w[4] = '{weight_t'(-128), weight_t'(127), weight_t'(0), weight_t'(-1)};
        tile_lo[4][0] = '{8'hff, 8'h00, 8'h80, 8'h01};
        tile_hi[4][0] = '{8'hff, 8'hff, 8'hff, 8'hff};
    endtask

    // signed dot product of one weight with one pixel lane
    function automatic result_t dot(int t, int i, int j, bit use_hi);
        int sum;
        sum = 0;
        for (int k = 0; k < tile_len[t]; k++) begin
            sum += int'(tile_w[t][i]) * int'(use_hi ? tile_hi[t][k][j] : tile_lo[t][k][j]);
        end
        return result_t'(sum);
    endfunction

    task automatic fill_expected();
        for (int t = 0; t < num_tiles; t++) begin
            for (int i = 0; i < rows; i++) begin
                for (int j = 0; j < cols; j++) begin
                    exp_lo[t][i][j] = dot(t, i, j, 1'b0);
                    exp_hi[t][i][j] = (tile_mode[t] == mode_pair) ? dot(t, i, j, 1'b1) : '0;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_result(input result_t got, input result_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "result check failed");
        end
    endtask

    task automatic check_row(input result_t got [2*cols], input result_t exp [2*cols],
                             input string what);
        for (int s = 0; s < 2*cols; s++) begin
            check_result(got[s], exp[s], $sformatf("%s slot %0d", what, s));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // drive sequences
    ////////////////////////////////////////////////////////////////////////////

    task automatic pulse_reset(input sa_mode_e m);
        @(posedge clk);
        #2;
        mode_init         = m;
        channel_out_reset = 1'b1;   // mode latched while high
        repeat (2) @(posedge clk);
        #2;
        channel_out_reset = 1'b0;
        exp_row  = 0;
        cur_mode = m;
    endtask

    task automatic apply_tile(input int t);
        for (int k = 0; k < tile_len[t]; k++) begin
            @(posedge clk);
            #2;
            en    = 1'b1;
            clear = (k == 0);       // first pair drops old sums
            for (int i = 0; i < rows; i++) begin
                row_in[i] = tile_w[t][i];
            end
            for (int j = 0; j < cols; j++) begin
                column_in[j] = {tile_hi[t][k][j], tile_lo[t][k][j]};
            end
        end
        @(posedge clk);
        #2;
        en        = 1'b0;
        clear     = 1'b0;
        row_in    = '{default: '0};
        column_in = '{default: '0};
    endtask

    task automatic settle_idle();
        repeat (settle_cycles) begin
            @(negedge clk);
            check_row(out, zero_row, "idle output");
        end
    endtask

    // rows+1 reads, so every tile also sees the wrap
    task automatic read_rows(input int t);
        result_t exp_vec [2*cols];
        for (int n = 0; n <= rows; n++) begin
            @(posedge clk);
            #2;
            channel_out_en = 1'b1;
            @(negedge clk);
            for (int j = 0; j < cols; j++) begin
                exp_vec[j]      = exp_lo[t][exp_row][j];
                exp_vec[cols+j] = exp_hi[t][exp_row][j];
            end
            check_row(out, exp_vec, $sformatf("tile %0d read %0d row %0d", t, n, exp_row));
            exp_row = (exp_row + 1) % rows;
        end
        @(posedge clk);
        #2;
        channel_out_en = 1'b0;
        @(negedge clk);
        check_row(out, zero_row, "output after read-out");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        channel_out_reset = 1'b1;
        en                = 1'b0;
        clear             = 1'b0;
        channel_out_en    = 1'b0;
        row_in            = '{default: '0};
        column_in         = '{default: '0};
        zero_row          = '{default: '0};
        build_table();
        fill_expected();
        mode_init = tile_mode[0];
        limit_cycles = reset_cycles;
        for (int t = 0; t < num_tiles; t++) begin
            limit_cycles += tile_len[t] + 3*rows + 10;
        end
        table_ready = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        #2;
        channel_out_reset = 1'b0;
        cur_mode = tile_mode[0];
        exp_row  = 0;

        for (int t = 0; t < num_tiles; t++) begin
            if (tile_mode[t] != cur_mode) begin
                pulse_reset(tile_mode[t]);
            end
            apply_tile(t);
            settle_idle();
            read_rows(t);
        end

        $display("** PASS **");
        $finish;
    end

    initial begin
        wait (table_ready);
        #(limit_cycles * clk_period);
        $display("timeout: test sequence did not finish within %0d cycles", limit_cycles);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- project.f
sa_pkg.sv
sa_operand_if.sv
sa_operand_packer.sv
sa_pe.sv
sa_array.sv
sa_row_drain.sv
sa_top.sv
tb_clock_gen.sv
tb_sa_top.sv

//--- Bender.yml
package:
  name: sa_systolic_array

dependencies: {}

sources:
  # design, in compile order
  - sa_pkg.sv
  - sa_operand_if.sv
  - sa_operand_packer.sv
  - sa_pe.sv
  - sa_array.sv
  - sa_row_drain.sv
  - sa_top.sv
  # testbench
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_sa_top.sv
